// File: src/ciph_ctrl_defines.svh
`ifndef CIPH_CTRL_DEFINES_SVH
`define CIPH_CTRL_DEFINES_SVH

// Width of one sparse two-valued signal

// Each bit of a sparse signal feeds its own rail, so this is also the rail count
`define SP2V_WIDTH 3

// Round counter, wide enough for 14 rounds
`define RND_CTR_WIDTH 4

`endif

// File: src/ciph_ctrl_pkg.sv
`default_nettype none

`include "ciph_ctrl_defines.svh"

package ciph_ctrl_pkg;

  // Sparse two-valued code, all other values are invalid
  typedef enum logic [`SP2V_WIDTH-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Rails whose bit is set here read a logic one as true
  localparam logic [`SP2V_WIDTH-1:0] sp2v_logic_high = 3'b011;

  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10
  } key_len_e;

  // State register input mux
  typedef enum logic [2:0] {
    STATE_HOLD  = 3'b001,
    STATE_INIT  = 3'b010,
    STATE_ROUND = 3'b100
  } state_sel_e;

  // Add-round-key operand select
  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  function automatic logic [`RND_CTR_WIDTH-1:0] num_rounds(key_len_e key_len);
    logic [`RND_CTR_WIDTH-1:0] nr;
    case (key_len)
      AES_192: nr = `RND_CTR_WIDTH'(12);
      AES_256: nr = `RND_CTR_WIDTH'(14);
      default: nr = `RND_CTR_WIDTH'(10); // AES_128 and the unused code
    endcase
    return nr;
  endfunction

endpackage

`default_nettype wire

// File: src/rail_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

// Control outputs of one rail on their way to the combiner
interface rail_ctrl_if;

  // Handshake and enable bits in the polarity of the rail
  logic                       in_ready;
  logic                       out_valid;
  logic                       state_we;

  // Sparse selects and counter, same encoding on every rail
  ciph_ctrl_pkg::state_sel_e  state_sel;
  ciph_ctrl_pkg::add_rk_sel_e add_rk_sel;
  logic [`RND_CTR_WIDTH-1:0]  rnd_ctr;
  logic                       alert;

  modport rail (
    output in_ready, out_valid, state_we, state_sel, add_rk_sel, rnd_ctr, alert
  );

  modport comb (
    input  in_ready, out_valid, state_we, state_sel, add_rk_sel, rnd_ctr, alert
  );

endinterface

`default_nettype wire

// File: src/sp2v_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

// Splits a sparse signal into its rail bits and checks the code
module sp2v_chk (
  input  ciph_ctrl_pkg::sp2v_e    sel_i,
  output logic [`SP2V_WIDTH-1:0]  sel_o,
  output logic                    err_o
);

  always_comb begin : check
    case (sel_i)
      ciph_ctrl_pkg::SP2V_HIGH,
      ciph_ctrl_pkg::SP2V_LOW: begin
        sel_o = sel_i;
        err_o = 1'b0;
      end
      default: begin
        // Invalid code reads as low on every rail
        sel_o = ciph_ctrl_pkg::SP2V_LOW;
        err_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/sel_combine.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

// OR-combines one select across all rails
module sel_combine #(
  parameter type sel_t = logic [2:0]
) (
  input  sel_t sel_i [`SP2V_WIDTH],
  output sel_t sel_o,
  output logic mismatch_o
);

  always_comb begin : combine
    sel_o      = sel_t'(0);
    mismatch_o = 1'b0;

    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      sel_o = sel_t'(sel_o | sel_i[i]);
    end

    // A differing rail may still OR into a valid code, so compare each one
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      if (sel_i[i] != sel_o) begin
        mismatch_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/ciph_ctrl_rail.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

module ciph_ctrl_rail #(
  parameter bit RailActiveLow = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  logic                    in_valid_i,   // Rail bit
  input  logic                    out_ready_i,  // Rail bit
  input  ciph_ctrl_pkg::key_len_e key_len_i,

  input  logic                    sp_enc_err_i,
  input  logic                    mr_err_i,

  rail_ctrl_if.rail               ctrl_o
);

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    INIT   = 3'd1,
    ROUND  = 3'd2,
    FINISH = 3'd3,
    ERROR  = 3'd4
  } state_e;

  state_e                    state_d, state_q;
  logic [`RND_CTR_WIDTH-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [`RND_CTR_WIDTH-1:0] num_rnd_d, num_rnd_q;
  logic                      in_valid;
  logic                      out_ready;
  logic                      in_ready;
  logic                      out_valid;
  logic                      state_we;
  logic                      last_rnd;

  // Bring the handshakes into true polarity
  assign in_valid  = in_valid_i ^ RailActiveLow;
  assign out_ready = out_ready_i ^ RailActiveLow;
  assign last_rnd  = (rnd_ctr_q == num_rnd_q);

  ////////////////////////////////////////////////////////////////////////////
  // FSM

  always_comb begin : fsm_next
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    num_rnd_d = num_rnd_q;

    case (state_q)
      IDLE: begin
        if (in_valid) begin // in_ready is high in IDLE
          state_d   = INIT;
          rnd_ctr_d = '0;
          num_rnd_d = ciph_ctrl_pkg::num_rounds(key_len_i);
        end
      end
      INIT: begin
        state_d   = ROUND;
        rnd_ctr_d = `RND_CTR_WIDTH'(1);
      end
      ROUND: begin
        if (last_rnd) begin
          state_d = FINISH;
        end else begin
          rnd_ctr_d = rnd_ctr_q + 1'b1;
        end
      end
      FINISH: begin
        if (out_ready) begin
          state_d   = IDLE;
          rnd_ctr_d = '0;
        end
      end
      default: state_d = ERROR; // Terminal, also catches illegal states
    endcase

    // Any error wins, whatever the state
    if (sp_enc_err_i || mr_err_i) begin
      state_d = ERROR;
    end
  end

  always_comb begin : fsm_out
    in_ready          = 1'b0;
    out_valid         = 1'b0;
    state_we          = 1'b0;
    ctrl_o.state_sel  = ciph_ctrl_pkg::STATE_HOLD;
    ctrl_o.add_rk_sel = ciph_ctrl_pkg::ADD_RK_INIT;
    ctrl_o.alert      = 1'b0;

    case (state_q)
      IDLE:   in_ready = 1'b1;
      INIT: begin
        state_we         = 1'b1;
        ctrl_o.state_sel = ciph_ctrl_pkg::STATE_INIT;
      end
      ROUND: begin
        state_we          = 1'b1;
        ctrl_o.state_sel  = ciph_ctrl_pkg::STATE_ROUND;
        ctrl_o.add_rk_sel = last_rnd ? ciph_ctrl_pkg::ADD_RK_FINAL : ciph_ctrl_pkg::ADD_RK_ROUND;
      end
      FINISH: out_valid = 1'b1;
      default: ctrl_o.alert = 1'b1;
    endcase
  end

  // Back to rail polarity
  assign ctrl_o.in_ready  = in_ready ^ RailActiveLow;
  assign ctrl_o.out_valid = out_valid ^ RailActiveLow;
  assign ctrl_o.state_we  = state_we ^ RailActiveLow;
  assign ctrl_o.rnd_ctr   = rnd_ctr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      state_q   <= IDLE;
      rnd_ctr_q <= '0;
      num_rnd_q <= '0;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      num_rnd_q <= num_rnd_d;
    end
  end

  RndCtrMax_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rnd_ctr_q <= `RND_CTR_WIDTH'(14));

endmodule

`default_nettype wire

// File: src/ciph_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

module ciph_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  ciph_ctrl_pkg::sp2v_e       in_valid_i,
  output ciph_ctrl_pkg::sp2v_e       in_ready_o,
  output ciph_ctrl_pkg::sp2v_e       out_valid_o,
  input  ciph_ctrl_pkg::sp2v_e       out_ready_i,

  input  ciph_ctrl_pkg::key_len_e    key_len_i,

  output ciph_ctrl_pkg::sp2v_e       state_we_o,
  output ciph_ctrl_pkg::state_sel_e  state_sel_o,
  output ciph_ctrl_pkg::add_rk_sel_e add_rk_sel_o,
  output logic [`RND_CTR_WIDTH-1:0]  round_o,
  output logic                       alert_o
);

  logic [`SP2V_WIDTH-1:0]     sp_in_valid;
  logic [`SP2V_WIDTH-1:0]     sp_out_ready;
  logic [`SP2V_WIDTH-1:0]     sp_in_ready;
  logic [`SP2V_WIDTH-1:0]     sp_out_valid;
  logic [`SP2V_WIDTH-1:0]     sp_state_we;
  logic [`SP2V_WIDTH-1:0]     mr_alert;

  ciph_ctrl_pkg::state_sel_e  mr_state_sel  [`SP2V_WIDTH];
  ciph_ctrl_pkg::add_rk_sel_e mr_add_rk_sel [`SP2V_WIDTH];
  logic [`RND_CTR_WIDTH-1:0]  mr_rnd_ctr    [`SP2V_WIDTH];
  logic [`RND_CTR_WIDTH-1:0]  rnd_ctr;

  logic                       in_valid_err;
  logic                       out_ready_err;
  logic                       state_sel_err;
  logic                       add_rk_sel_err;
  logic                       rnd_ctr_err;
  logic                       sp_enc_err;
  logic                       mr_err;

  ////////////////////////////////////////////////////////////////////////////
  // Sparse input checks

  sp2v_chk u_in_valid_chk (
    .sel_i ( in_valid_i   ),
    .sel_o ( sp_in_valid  ),
    .err_o ( in_valid_err )
  );

  sp2v_chk u_out_ready_chk (
    .sel_i ( out_ready_i   ),
    .sel_o ( sp_out_ready  ),
    .err_o ( out_ready_err )
  );

  assign sp_enc_err = in_valid_err | out_ready_err;

  ////////////////////////////////////////////////////////////////////////////
  // Rails, one per sparse bit

  rail_ctrl_if rail_if [`SP2V_WIDTH] ();

  for (genvar i = 0; i < `SP2V_WIDTH; i++) begin : gen_rail
    ciph_ctrl_rail #(
      .RailActiveLow ( !ciph_ctrl_pkg::sp2v_logic_high[i] )
    ) u_rail (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .in_valid_i   ( sp_in_valid[i]  ),
      .out_ready_i  ( sp_out_ready[i] ),
      .key_len_i    ( key_len_i       ),
      .sp_enc_err_i ( sp_enc_err      ),
      .mr_err_i     ( mr_err          ),
      .ctrl_o       ( rail_if[i]      )
    );

    assign sp_in_ready[i]   = rail_if[i].in_ready;
    assign sp_out_valid[i]  = rail_if[i].out_valid;
    assign sp_state_we[i]   = rail_if[i].state_we;
    assign mr_state_sel[i]  = rail_if[i].state_sel;  // OR-combined
    assign mr_add_rk_sel[i] = rail_if[i].add_rk_sel; // OR-combined
    assign mr_rnd_ctr[i]    = rail_if[i].rnd_ctr;    // OR-combined
    assign mr_alert[i]      = rail_if[i].alert;
  end

  // Rail bits back to sparse codes
  assign in_ready_o  = ciph_ctrl_pkg::sp2v_e'(sp_in_ready);
  assign out_valid_o = ciph_ctrl_pkg::sp2v_e'(sp_out_valid);
  assign state_we_o  = ciph_ctrl_pkg::sp2v_e'(sp_state_we);
  assign alert_o     = |mr_alert;

  ////////////////////////////////////////////////////////////////////////////
  // Combining and error collection

  sel_combine #(.sel_t(ciph_ctrl_pkg::state_sel_e)) u_state_sel_comb (
    .sel_i      ( mr_state_sel  ),
    .sel_o      ( state_sel_o   ),
    .mismatch_o ( state_sel_err )
  );

  sel_combine #(.sel_t(ciph_ctrl_pkg::add_rk_sel_e)) u_add_rk_sel_comb (
    .sel_i      ( mr_add_rk_sel  ),
    .sel_o      ( add_rk_sel_o   ),
    .mismatch_o ( add_rk_sel_err )
  );

  always_comb begin : combine_rnd_ctr
    rnd_ctr     = '0;
    rnd_ctr_err = 1'b0;
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      rnd_ctr |= mr_rnd_ctr[i];
    end
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      rnd_ctr_err |= (mr_rnd_ctr[i] != rnd_ctr);
    end
  end

  assign round_o = rnd_ctr;
  assign mr_err  = state_sel_err | add_rk_sel_err | rnd_ctr_err;

  // Invalid key length is tolerated and runs 10 rounds
  KeyLenValid_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (in_valid_i == ciph_ctrl_pkg::SP2V_HIGH && in_ready_o == ciph_ctrl_pkg::SP2V_HIGH) |->
      key_len_i inside {ciph_ctrl_pkg::AES_128, ciph_ctrl_pkg::AES_192, ciph_ctrl_pkg::AES_256})
    else $warning("Invalid key length accepted");

  HandshakeExcl_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(out_valid_o == ciph_ctrl_pkg::SP2V_HIGH && in_ready_o == ciph_ctrl_pkg::SP2V_HIGH));

  AlertSticky_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
      alert_o |=> alert_o);

endmodule

`default_nettype wire

// File: sim/tb_ciph_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ciph_ctrl_defines.svh"

module tb_ciph_ctrl;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  ciph_ctrl_pkg::sp2v_e       in_valid_i;
  ciph_ctrl_pkg::sp2v_e       in_ready_o;
  ciph_ctrl_pkg::sp2v_e       out_valid_o;
  ciph_ctrl_pkg::sp2v_e       out_ready_i;
  ciph_ctrl_pkg::key_len_e    key_len_i;
  ciph_ctrl_pkg::sp2v_e       state_we_o;
  ciph_ctrl_pkg::state_sel_e  state_sel_o;
  ciph_ctrl_pkg::add_rk_sel_e add_rk_sel_o;
  logic [`RND_CTR_WIDTH-1:0]  round_o;
  logic                       alert_o;

  integer seed;
  int     num_checks;
  int     num_mismatch;
  int     num_fail;     // Timeouts and file problems

  always #50 clk_i = ~clk_i;

  ciph_ctrl dut0 (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .in_valid_i   ( in_valid_i   ),
    .in_ready_o   ( in_ready_o   ),
    .out_valid_o  ( out_valid_o  ),
    .out_ready_i  ( out_ready_i  ),
    .key_len_i    ( key_len_i    ),
    .state_we_o   ( state_we_o   ),
    .state_sel_o  ( state_sel_o  ),
    .add_rk_sel_o ( add_rk_sel_o ),
    .round_o      ( round_o      ),
    .alert_o      ( alert_o      )
  );

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    num_checks++;
    if (got !== exp) begin
      num_mismatch++;
      $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reset and transactions

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_equal(in_ready_o, ciph_ctrl_pkg::SP2V_HIGH, "in_ready after reset");
    check_equal(out_valid_o, ciph_ctrl_pkg::SP2V_LOW, "out_valid after reset");
    check_equal(state_we_o, ciph_ctrl_pkg::SP2V_LOW, "state_we after reset");
    check_equal(alert_o, 1'b0, "alert after reset");
  endtask

  // Ends in the INIT cycle
  task automatic start_transaction(input int kl);
    int cnt;
    cnt = 0;
    @(posedge clk_i);
    in_valid_i <= ciph_ctrl_pkg::SP2V_HIGH;
    key_len_i  <= ciph_ctrl_pkg::key_len_e'(kl[1:0]);
    @(negedge clk_i);
    while (in_ready_o !== ciph_ctrl_pkg::SP2V_HIGH && cnt < 20) begin
      @(negedge clk_i);
      cnt++;
    end
    if (in_ready_o !== ciph_ctrl_pkg::SP2V_HIGH) begin
      num_fail++;
      $display("Timeout: the sequencer never became ready to accept input");
    end
    @(posedge clk_i); // Accepting edge
    in_valid_i <= ciph_ctrl_pkg::SP2V_LOW;
    @(negedge clk_i);
    check_equal(state_we_o, ciph_ctrl_pkg::SP2V_HIGH, "state_we in INIT");
    check_equal(state_sel_o, ciph_ctrl_pkg::STATE_INIT, "state_sel in INIT");
    check_equal(add_rk_sel_o, ciph_ctrl_pkg::ADD_RK_INIT, "add_rk_sel in INIT");
    check_equal(round_o, 0, "round in INIT");
    check_equal(in_ready_o, ciph_ctrl_pkg::SP2V_LOW, "in_ready in INIT");
  endtask

  task automatic run_transaction(input int kl, input int stall, input int nr);
    int cyc;
    bit done;
    cyc  = 0;
    done = 1'b0;
    start_transaction(kl);
    while (!done && cyc < 40) begin
      @(negedge clk_i);
      cyc++;
      if (out_valid_o === ciph_ctrl_pkg::SP2V_HIGH) begin
        done = 1'b1;
      end else begin
        check_equal(round_o, cyc, "round number");
        check_equal(state_we_o, ciph_ctrl_pkg::SP2V_HIGH, "state_we in round");
        check_equal(state_sel_o, ciph_ctrl_pkg::STATE_ROUND, "state_sel in round");
        check_equal(add_rk_sel_o, (cyc == nr) ? ciph_ctrl_pkg::ADD_RK_FINAL :
                    ciph_ctrl_pkg::ADD_RK_ROUND, "add_rk_sel in round");
      end
    end
    if (!done) begin
      num_fail++;
      $display("Timeout: out_valid never rose after %0d cycles", cyc);
    end else begin
      check_equal(cyc, nr + 1, "cycles from INIT to out_valid");
    end
    // Back-pressure, the result must hold
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check_equal(out_valid_o, ciph_ctrl_pkg::SP2V_HIGH, "out_valid under back-pressure");
      check_equal(state_we_o, ciph_ctrl_pkg::SP2V_LOW, "state_we under back-pressure");
      check_equal(in_ready_o, ciph_ctrl_pkg::SP2V_LOW, "in_ready under back-pressure");
    end
    @(posedge clk_i);
    out_ready_i <= ciph_ctrl_pkg::SP2V_HIGH;
    @(posedge clk_i); // Output taken here
    out_ready_i <= ciph_ctrl_pkg::SP2V_LOW;
    @(negedge clk_i);
    check_equal(in_ready_o, ciph_ctrl_pkg::SP2V_HIGH, "in_ready after output taken");
    check_equal(out_valid_o, ciph_ctrl_pkg::SP2V_LOW, "out_valid after output taken");
  endtask

  task automatic inject_fault();
    int cnt;
    @(posedge clk_i);
    in_valid_i <= ciph_ctrl_pkg::sp2v_e'(3'b000);
    @(posedge clk_i); // Invalid code seen on this edge
    in_valid_i <= ciph_ctrl_pkg::SP2V_LOW;
    @(negedge clk_i);
    cnt = 1;
    while (alert_o !== 1'b1 && cnt < 2) begin
      @(negedge clk_i);
      cnt++;
    end
    if (alert_o !== 1'b1) begin
      num_fail++;
      $display("Timeout: alert did not rise within 2 cycles of the invalid code");
    end
    repeat (5) begin
      @(negedge clk_i);
      check_equal(alert_o, 1'b1, "alert after fault");
      check_equal(in_ready_o, ciph_ctrl_pkg::SP2V_LOW, "in_ready after fault");
      check_equal(out_valid_o, ciph_ctrl_pkg::SP2V_LOW, "out_valid after fault");
      check_equal(state_we_o, ciph_ctrl_pkg::SP2V_LOW, "state_we after fault");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Golden file driven test sequence

  initial begin : main
    int    fd;
    string line;
    int    kind;
    int    kl;
    int    stall;
    int    nr;
    int    gap;
    int    num_tests;
    seed         = 32'hd2a99b41;
    num_checks   = 0;
    num_mismatch = 0;
    num_fail     = 0;
    num_tests    = 0;
    rst_ni       = 1'b0;
    in_valid_i   = ciph_ctrl_pkg::SP2V_LOW;
    out_ready_i  = ciph_ctrl_pkg::SP2V_LOW;
    key_len_i    = ciph_ctrl_pkg::AES_128;
    apply_reset();

    fd = $fopen("sim/ciph_ctrl_golden.txt", "r");
    if (fd == 0) begin
      num_fail++;
      $display("Could not open the golden file sim/ciph_ctrl_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%d %d %d %d", kind, kl, stall, nr) == 4) begin
          num_tests++;
          gap = $unsigned($random(seed)) % 4; // Idle gap between transactions
          repeat (gap) @(posedge clk_i);
          case (kind)
            0: run_transaction(kl, stall, nr);
            1: begin
              inject_fault();
              apply_reset();
              run_transaction(kl, stall, nr);
            end
            2: begin
              start_transaction(kl);
              repeat (3) @(negedge clk_i); // Fault lands in the rounds
              inject_fault();
              apply_reset();
              run_transaction(kl, stall, nr);
            end
            default: begin
              num_fail++;
              $display("Unknown test kind %0d in the golden file", kind);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    if (num_tests == 0) begin
      num_fail++;
      $display("No test lines were read from the golden file");
    end

    $display("Tests: %0d, checks: %0d, mismatches: %0d, other failures: %0d",
             num_tests, num_checks, num_mismatch, num_fail);
    if (num_mismatch == 0 && num_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/ciph_ctrl_golden.txt
# columns: kind key_len stall_cycles expected_rounds (decimal)
# kind 0 normal, 1 sparse fault while idle, 2 sparse fault during rounds
0 0 0 10
0 1 2 12
0 2 5 14
0 3 1 10
0 0 3 10
0 2 0 14
1 1 2 12
0 1 4 12
2 0 1 10
0 3 0 10
2 2 3 14
0 2 7 14
1 3 0 10
2 1 2 12
0 0 6 10
0 1 1 12

// File: all.f
+incdir+src
src/ciph_ctrl_pkg.sv
src/rail_ctrl_if.sv
src/sp2v_chk.sv
src/sel_combine.sv
src/ciph_ctrl_rail.sv
src/ciph_ctrl.sv
sim/tb_ciph_ctrl.sv
